// ==== filelist.f ====
+incdir+include
rtl/iq_types_pkg.sv
rtl/iq_ctrl_pkg.sv
rtl/fifo_if.sv
rtl/fifo.sv
rtl/read_iq.sv
rtl/iq_frontend_top.sv
sim/iq_frontend_properties.sv
sim/iq_checker.sv
sim/iq_frontend_tb.sv

// ==== Makefile ====
TOP := iq_frontend_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== sim/iq_frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_defines.svh"

module iq_frontend_tb;

    localparam int SEED        = 68;
    localparam int NUM_SAMPLES = 400;
    localparam int NUM_BYTES   = NUM_SAMPLES * 4;
    localparam int TIMEOUT     = NUM_BYTES * 20;
    // several pair times of empty outputs mark the end of the drain.
    localparam int DRAIN_QUIET = 20;

    logic                  clock;
    logic                  reset;
    logic                  in_wr_en;
    logic [`BYTE_SIZE-1:0] in_data;
    logic                  in_full;
    logic                  i_pop;
    logic [`DATA_SIZE-1:0] i_sample;
    logic                  i_empty;
    logic                  q_pop;
    logic [`DATA_SIZE-1:0] q_sample;
    logic                  q_empty;

    logic [7:0] stream[$];
    int pushed      = 0;
    int cycles      = 0;
    int full_cycles = 0;
    int tb_errors   = 0;
    int mismatch_count;
    int other_count;
    int i_count;
    int q_count;
    int pending;

    iq_frontend_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .i_in_wr_en (in_wr_en),
        .i_in_data  (in_data),
        .o_in_full  (in_full),
        .i_i_rd_en  (i_pop),
        .o_i_data   (i_sample),
        .o_i_empty  (i_empty),
        .i_q_rd_en  (q_pop),
        .o_q_data   (q_sample),
        .o_q_empty  (q_empty)
    );

    iq_checker u_checker (
        .clock            (clock),
        .reset            (reset),
        .i_push           (in_wr_en),
        .i_byte           (in_data),
        .i_in_full        (in_full),
        .i_i_pop          (i_pop),
        .i_i_data         (i_sample),
        .i_i_empty        (i_empty),
        .i_q_pop          (q_pop),
        .i_q_data         (q_sample),
        .i_q_empty        (q_empty),
        .o_mismatch_count (mismatch_count),
        .o_other_count    (other_count),
        .o_i_count        (i_count),
        .o_q_count        (q_count),
        .o_pending        (pending)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not complete within %0d cycles", TIMEOUT);
            $display("error counts: %0d mismatches, %0d other", mismatch_count,
                     other_count + tb_errors + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    // extremes are picked often.
    function automatic logic [15:0] pick_raw();
        case ($urandom_range(0, 7))
            0:       return 16'h8000;
            1:       return 16'h7FFF;
            2:       return 16'h0000;
            3:       return 16'hFFFF;
            default: return 16'($urandom);
        endcase
    endfunction

    task automatic build_stream();
        logic [15:0] iv;
        logic [15:0] qv;
        for (int n = 0; n < NUM_SAMPLES; n++) begin
            iv = pick_raw();
            qv = pick_raw();
            stream.push_back(iv[7:0]);
            stream.push_back(iv[15:8]);
            stream.push_back(qv[7:0]);
            stream.push_back(qv[15:8]);
        end
    endtask

    task automatic push_bytes();
        int gap;
        while (pushed < NUM_BYTES) begin
            @(posedge clock);
            #1;
            if (in_full) begin
                full_cycles++;
            end
            if ($urandom_range(0, 63) == 0) begin
                // long stall, often in the middle of a quadruple.
                in_wr_en = 1'b0;
                gap = $urandom_range(1, 20);
                repeat (gap) @(posedge clock);
                #1;
            end
            if (!in_full && $urandom_range(0, 3) != 0) begin
                in_wr_en = 1'b1;
                in_data  = stream.pop_front();
                pushed++;
            end else begin
                in_wr_en = 1'b0;
            end
        end
        @(posedge clock);
        #1;
        in_wr_en = 1'b0;
    endtask

    // phases cycle through fast, slow and withheld popping.
    task automatic pop_samples();
        int phase;
        int chance;
        int quiet;
        quiet = 0;
        while (pushed < NUM_BYTES || quiet < DRAIN_QUIET) begin
            @(posedge clock);
            #1;
            if (pushed == NUM_BYTES && i_empty && q_empty) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            phase = (cycles / 600) % 3;
            if (pushed == NUM_BYTES) begin
                chance = 1;
            end else if (phase == 0) begin
                chance = 2;
            end else if (phase == 1) begin
                chance = 24;
            end else begin
                chance = 0;
            end
            i_pop = !i_empty && chance != 0 && $urandom_range(1, chance) == 1;
            q_pop = !q_empty && chance != 0 && $urandom_range(1, chance) == 1;
        end
        @(posedge clock);
        #1;
        i_pop = 1'b0;
        q_pop = 1'b0;
    endtask

    task automatic final_checks();
        if (i_count != NUM_SAMPLES || q_count != NUM_SAMPLES) begin
            $display("error: popped %0d I and %0d Q words instead of %0d each",
                     i_count, q_count, NUM_SAMPLES);
            tb_errors++;
        end
        if (!i_empty || !q_empty) begin
            $display("error: output FIFOs still hold data after the drain");
            tb_errors++;
        end
        if (pending != 0) begin
            $display("error: the model still holds %0d expected values or bytes", pending);
            tb_errors++;
        end
        if (full_cycles == 0) begin
            $display("error: input FIFO never filled, back-pressure went untested");
            tb_errors++;
        end
    endtask

    initial begin
        reset    = 1'b1;
        in_wr_en = 1'b0;
        in_data  = '0;
        i_pop    = 1'b0;
        q_pop    = 1'b0;
        void'($urandom(SEED));
        build_stream();
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        fork
            push_bytes();
            pop_samples();
        join
        repeat (4) @(posedge clock);
        #1;
        final_checks();
        $display("error counts: %0d mismatches, %0d other", mismatch_count,
                 other_count + tb_errors);
        if (mismatch_count == 0 && other_count == 0 && tb_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/iq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_defines.svh"

module iq_checker (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  i_push,
    input  wire logic [`BYTE_SIZE-1:0] i_byte,
    input  wire logic                  i_in_full,
    input  wire logic                  i_i_pop,
    input  wire logic [`DATA_SIZE-1:0] i_i_data,
    input  wire logic                  i_i_empty,
    input  wire logic                  i_q_pop,
    input  wire logic [`DATA_SIZE-1:0] i_q_data,
    input  wire logic                  i_q_empty,
    output int                         o_mismatch_count,
    output int                         o_other_count,
    output int                         o_i_count,
    output int                         o_q_count,
    output int                         o_pending
);

    int exp_i[$];
    int exp_q[$];
    logic [`BYTE_SIZE-1:0] quad [4];
    logic [1:0] slot = 2'd0;

    int mismatches = 0;
    int others     = 0;
    int i_seen     = 0;
    int q_seen     = 0;

    assign o_mismatch_count = mismatches;
    assign o_other_count    = others;
    assign o_i_count        = i_seen;
    assign o_q_count        = q_seen;
    assign o_pending        = exp_i.size() + exp_q.size() + int'(slot);

    // low byte first, two's complement, then scaled by 2**FRAC_BITS.
    function automatic int scale_raw(input logic [7:0] lo, input logic [7:0] hi);
        int v;
        v = int'({hi, lo});
        if (v >= 32768) begin
            v = v - 65536;
        end
        return v * (1 << `FRAC_BITS);
    endfunction

    task automatic compare_word(input string chan, input int expected,
                                input logic [`DATA_SIZE-1:0] observed);
        if (observed !== expected) begin
            $display("MISMATCH at %0t: channel %s expected %0d observed %0d",
                     $time, chan, expected, $signed(observed));
            mismatches++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // sampled mid-cycle, away from the DUT's edge.
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            if (i_push && !i_in_full) begin
                quad[slot] = i_byte;
                if (slot == 2'd3) begin
                    exp_i.push_back(scale_raw(quad[0], quad[1]));
                    exp_q.push_back(scale_raw(quad[2], quad[3]));
                end
                slot = slot + 2'd1;
            end
            if (i_i_pop && !i_i_empty) begin
                i_seen++;
                if (exp_i.size() == 0) begin
                    $display("error at %0t: I word popped with no sample expected", $time);
                    others++;
                end else begin
                    compare_word("I", exp_i.pop_front(), i_i_data);
                end
            end
            if (i_q_pop && !i_q_empty) begin
                q_seen++;
                if (exp_q.size() == 0) begin
                    $display("error at %0t: Q word popped with no sample expected", $time);
                    others++;
                end else begin
                    compare_word("Q", exp_q.pop_front(), i_q_data);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/iq_frontend_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module iq_frontend_properties (
    input wire logic clock,
    input wire logic reset,
    input wire logic i_in_rd_en,
    input wire logic i_in_empty,
    input wire logic i_i_wr_en,
    input wire logic i_i_full,
    input wire logic i_q_wr_en,
    input wire logic i_q_full
);

    // no byte popped from an empty input FIFO.
    pop_not_empty: assert property (
        @(posedge clock) disable iff (reset) i_in_rd_en |-> !i_in_empty
    ) else $error("read_iq popped the input FIFO while it was empty");

    // a write only when both outputs have room.
    write_not_full: assert property (
        @(posedge clock) disable iff (reset)
        (i_i_wr_en || i_q_wr_en) |-> !(i_i_full || i_q_full)
    ) else $error("read_iq wrote a sample while an output FIFO was full");

    // one write pulse per sample pair.
    single_write: assert property (
        @(posedge clock) disable iff (reset)
        (i_i_wr_en || i_q_wr_en) |=> !(i_i_wr_en || i_q_wr_en)
    ) else $error("read_iq held its output write pulse for two cycles");

endmodule

bind read_iq iq_frontend_properties u_properties (
    .clock      (clock),
    .reset      (reset),
    .i_in_rd_en (i_in.rd_en),
    .i_in_empty (i_in.empty),
    .i_i_wr_en  (o_i.wr_en),
    .i_i_full   (o_i.full),
    .i_q_wr_en  (o_q.wr_en),
    .i_q_full   (o_q.full)
);

`default_nettype wire

// ==== rtl/iq_frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "radio_defines.svh"

module iq_frontend_top (
    input  wire logic                 clock,
    input  wire logic                 reset,

    // byte stream in.
    input  wire logic                 i_in_wr_en,
    input  wire iq_types_pkg::byte_t  i_in_data,
    output logic                      o_in_full,

    // I samples out.
    input  wire logic                 i_i_rd_en,
    output iq_types_pkg::sample_t     o_i_data,
    output logic                      o_i_empty,

    // Q samples out.
    input  wire logic                 i_q_rd_en,
    output iq_types_pkg::sample_t     o_q_data,
    output logic                      o_q_empty
);

    fifo_if #(.WIDTH(`BYTE_SIZE)) in_bus ();
    fifo_if #(.WIDTH(`DATA_SIZE)) i_bus ();
    fifo_if #(.WIDTH(`DATA_SIZE)) q_bus ();

    // top ports stand in for the byte producer.
    assign in_bus.wr_en = i_in_wr_en;
    assign in_bus.din   = i_in_data;
    assign o_in_full    = in_bus.full;

    // and for the sample consumers.
    assign i_bus.rd_en = i_i_rd_en;
    assign o_i_data    = i_bus.dout;
    assign o_i_empty   = i_bus.empty;

    assign q_bus.rd_en = i_q_rd_en;
    assign o_q_data    = q_bus.dout;
    assign o_q_empty   = q_bus.empty;

    fifo #(
        .WIDTH (`BYTE_SIZE),
        .DEPTH (`IN_FIFO_DEPTH)
    ) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .i_bus (in_bus.fifo_side)
    );

    read_iq u_read_iq (
        .clock (clock),
        .reset (reset),
        .i_in  (in_bus.consumer),
        .o_i   (i_bus.producer),
        .o_q   (q_bus.producer)
    );

    fifo #(
        .WIDTH (`DATA_SIZE),
        .DEPTH (`OUT_FIFO_DEPTH)
    ) u_i_fifo (
        .clock (clock),
        .reset (reset),
        .i_bus (i_bus.fifo_side)
    );

    fifo #(
        .WIDTH (`DATA_SIZE),
        .DEPTH (`OUT_FIFO_DEPTH)
    ) u_q_fifo (
        .clock (clock),
        .reset (reset),
        .i_bus (q_bus.fifo_side)
    );

endmodule

`default_nettype wire

// ==== rtl/read_iq.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_iq (
    input  wire logic clock,
    input  wire logic reset,
    fifo_if.consumer  i_in,
    fifo_if.producer  o_i,
    fifo_if.producer  o_q
);

    import iq_types_pkg::*;
    import iq_ctrl_pkg::*;

    unpack_state_t state;
    unpack_state_t next_state;

    byte_t       i_lo;
    byte_t       q_lo;
    raw_sample_t i_raw;
    raw_sample_t q_raw;

    logic byte_state;
    logic pop;
    logic out_ready;
    logic write;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    assign byte_state = (state != WRITE);
    assign pop        = byte_state && !i_in.empty;
    assign out_ready  = !o_i.full && !o_q.full;
    assign write      = (state == WRITE) && out_ready;

    assign i_in.rd_en = pop;
    assign o_i.wr_en  = write;
    assign o_q.wr_en  = write;

    // outputs come from the held raw words.
    assign o_i.din = quantize(i_raw);
    assign o_q.din = quantize(q_raw);

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            I_LO:    if (pop) next_state = I_HI;
            I_HI:    if (pop) next_state = Q_LO;
            Q_LO:    if (pop) next_state = Q_HI;
            Q_HI:    if (pop) next_state = WRITE;
            WRITE:   if (out_ready) next_state = I_LO;
            default: next_state = I_LO;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= I_LO;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // byte assembly
    //////////////////////////////////////////////////////////////////////

    // low byte first, high byte completes the word.
    always_ff @(posedge clock) begin
        if (pop) begin
            case (state)
                I_LO:    i_lo  <= i_in.dout;
                I_HI:    i_raw <= {i_in.dout, i_lo};
                Q_LO:    q_lo  <= i_in.dout;
                Q_HI:    q_raw <= {i_in.dout, q_lo};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire logic  clock,
    input  wire logic  reset,
    fifo_if.fifo_side  i_bus
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign i_bus.full  = (count == CNT_W'(DEPTH));
    assign i_bus.empty = (count == '0);

    // head word falls through.
    assign i_bus.dout = mem[rd_ptr];

    assign push = i_bus.wr_en && !i_bus.full;
    assign pop  = i_bus.rd_en && !i_bus.empty;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= i_bus.din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the level alone.
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
    parameter int WIDTH = 8
);

    // write side.
    logic             wr_en;
    logic [WIDTH-1:0] din;
    logic             full;

    // read side.
    logic             rd_en;
    logic [WIDTH-1:0] dout;
    logic             empty;

    modport fifo_side (
        input  wr_en,
        input  din,
        input  rd_en,
        output full,
        output empty,
        output dout
    );

    modport producer (
        output wr_en,
        output din,
        input  full
    );

    modport consumer (
        output rd_en,
        input  dout,
        input  empty
    );

endinterface

`default_nettype wire

// ==== rtl/iq_ctrl_pkg.sv ====
`default_nettype none

package iq_ctrl_pkg;

    // one state per byte of the quadruple, then the output write.
    typedef enum logic [2:0] {
        I_LO,
        I_HI,
        Q_LO,
        Q_HI,
        WRITE
    } unpack_state_t;

endpackage

`default_nettype wire

// ==== rtl/iq_types_pkg.sv ====
`default_nettype none

`include "radio_defines.svh"

package iq_types_pkg;

    // one stream byte.
    typedef logic [`BYTE_SIZE-1:0] byte_t;

    // two's complement I or Q as it arrives.
    typedef logic signed [`CHAR_SIZE-1:0] raw_sample_t;

    // fixed-point sample, FRAC_BITS below the point.
    typedef logic signed [`DATA_SIZE-1:0] sample_t;

    // sign-extend, then scale into the fixed-point format.
    function automatic sample_t quantize(input raw_sample_t raw);
        sample_t wide;
        wide = sample_t'(raw);
        return wide <<< `FRAC_BITS;
    endfunction

endpackage

`default_nettype wire

// ==== include/radio_defines.svh ====
`ifndef RADIO_DEFINES_SVH
`define RADIO_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// stream and sample widths
//////////////////////////////////////////////////////////////////////

// one byte of the raw baseband stream.
`define BYTE_SIZE 8

// raw I or Q value, two bytes.
`define CHAR_SIZE 16

// fixed-point sample used by the later radio stages.
`define DATA_SIZE 32
`define FRAC_BITS 10

//////////////////////////////////////////////////////////////////////
// buffering
//////////////////////////////////////////////////////////////////////

`define IN_FIFO_DEPTH 16
`define OUT_FIFO_DEPTH 16

`endif
